// ==== sim.f ====
+incdir+include
hdl/csr_pkg.sv
hdl/csrDecode.sv
hdl/csrAccess.sv
hdl/csrRegFile.sv
hdl/csrUnit.sv
test/csrChecker.sv
test/csrUnitTb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/csr_pkg.sv
      - hdl/csrDecode.sv
      - hdl/csrAccess.sv
      - hdl/csrRegFile.sv
      - hdl/csrUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/csrChecker.sv
      - test/csrUnitTb.sv

// ==== test/csrUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csrUnitTb import csr_pkg::*; ();

    localparam logic [31:0] INSTR_MRET = 32'h30200073;
    localparam logic [2:0]  F_RW  = 3'b001;   // Zicsr funct3 codes
    localparam logic [2:0]  F_RS  = 3'b010;
    localparam logic [2:0]  F_RC  = 3'b011;
    localparam logic [2:0]  F_RSI = 3'b110;
    localparam logic [2:0]  F_RCI = 3'b111;
    localparam int          MAXT  = 32;

    logic              CLK;
    logic              RESET;
    logic              req;
    logic              ack;
    logic [31:0]       instr;
    logic [`XLEN-1:0]  rs1Value;
    logic [`XLEN-1:0]  rdValue;
    logic              illegal;
    logic              redirectValid;
    logic [`XLEN-1:0]  redirectPc;
    logic              trapValid;
    logic [`XLEN-1:0]  trapCause;
    logic [`XLEN-1:0]  trapNpc;
    logic              trapRedirectValid;
    logic [`XLEN-1:0]  trapRedirectPc;
    privE              priv;

    // Stimulus table with one column per array
    logic              tabKind  [MAXT];   // Set for a trap entry
    logic [31:0]       tabInstr [MAXT];
    logic [`XLEN-1:0]  tabCause [MAXT];
    logic [`XLEN-1:0]  tabArg   [MAXT];   // rs1 operand or trap NPC
    logic [`XLEN-1:0]  tabRd    [MAXT];
    logic              tabIll   [MAXT];
    logic              tabRedir [MAXT];
    logic [`XLEN-1:0]  tabPc    [MAXT];   // Either redirect target
    logic [1:0]        tabPriv  [MAXT];
    int                nTests;
    logic              tableReady;

    // Reference model state
    logic [`XLEN-1:0]  mStatus;
    logic [`XLEN-1:0]  mTvec;
    logic [`XLEN-1:0]  mScratch;
    logic [`XLEN-1:0]  mEpc;
    logic [`XLEN-1:0]  mCause;
    logic [1:0]        mPriv;
    logic [31:0]       lfsrState;

    // Expected values handed to the checker
    int                curTest;
    logic              curKind;
    logic [`XLEN-1:0]  curRd;
    logic              curIll;
    logic              curRedir;
    logic [`XLEN-1:0]  curPc;
    logic [1:0]        curPriv;
    int                doneCount;
    int                errorCount;

    csrUnit csrUnit_inst (
        .CLK(CLK), .RESET(RESET), .req(req), .ack(ack), .instr(instr), .rs1Value(rs1Value),
        .rdValue(rdValue), .illegal(illegal),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .trapValid(trapValid), .trapCause(trapCause), .trapNpc(trapNpc),
        .trapRedirectValid(trapRedirectValid), .trapRedirectPc(trapRedirectPc), .priv(priv)
    );

    csrChecker csrChecker_inst (
        .CLK(CLK), .RESET(RESET), .trapValid(trapValid),
        .ack(ack), .rdValue(rdValue), .illegal(illegal),
        .redirectValid(redirectValid), .redirectPc(redirectPc),
        .trapRedirectValid(trapRedirectValid), .trapRedirectPc(trapRedirectPc), .priv(priv),
        .testIdx(curTest), .expKind(curKind), .expRd(curRd), .expIll(curIll),
        .expRedir(curRedir), .expPc(curPc), .expPriv(curPriv),
        .doneCount(doneCount), .errorCount(errorCount)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;   // 8 ns period
    end

    //////////////////////////////////////////////////
    // Random operands and instruction encoding
    //////////////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(output logic [`XLEN-1:0] v);
        v = '0;
        for (int b = 0; b < `XLEN; b++) begin
            lfsrState = lfsrStep(lfsrState);   // One step per bit
            v = {v[`XLEN-2:0], lfsrState[0]};
        end
    endtask

    function automatic logic [31:0] csrInstr(input logic [2:0] f3, input logic [11:0] csr,
                                             input logic [4:0] src);
        return {csr, src, f3, 5'd10, 7'b1110011};   // rd is x10
    endfunction

    //////////////////////////////////////////////////
    // Reference model filling one table row per call
    //////////////////////////////////////////////////
    task automatic addCsr(input logic [31:0] ins, input logic [`XLEN-1:0] opnd);
        logic [2:0]        f3;
        logic [11:0]       addr;
        logic [`XLEN-1:0]  oldV;
        logic [`XLEN-1:0]  src;
        logic [`XLEN-1:0]  newV;
        logic              impl;
        f3   = ins[14:12];
        addr = ins[31:20];
        impl = 1'b1;
        oldV = '0;
        tabKind[nTests]  = 1'b0;
        tabInstr[nTests] = ins;
        tabArg[nTests]   = opnd;
        tabRd[nTests]    = '0;
        tabIll[nTests]   = 1'b0;
        tabRedir[nTests] = 1'b0;
        tabPc[nTests]    = '0;
        if (ins == INSTR_MRET) begin
            tabRedir[nTests] = 1'b1;
            tabPc[nTests]    = mEpc;
            mPriv = mStatus[`MSTATUS_MPP_LO +: 2];
            mStatus[`MSTATUS_MIE]         = mStatus[`MSTATUS_MPIE];
            mStatus[`MSTATUS_MPIE]        = 1'b1;
            mStatus[`MSTATUS_MPP_LO +: 2] = PRIV_U;
        end else if (ins[6:0] != 7'b1110011 || f3 == 3'b000 || f3 == 3'b100) begin
            tabIll[nTests] = 1'b1;   // Not a Zicsr instruction
        end else begin
            case (addr)
                `CSR_MSTATUS:  oldV = mStatus;
                `CSR_MTVEC:    oldV = mTvec;
                `CSR_MSCRATCH: oldV = mScratch;
                `CSR_MEPC:     oldV = mEpc;
                `CSR_MCAUSE:   oldV = mCause;
                default:       impl = 1'b0;
            endcase
            if (!impl || mPriv < addr[9:8]) begin
                tabIll[nTests] = 1'b1;
            end else begin
                tabRd[nTests] = oldV;
                src = f3[2] ? {{(`XLEN-5){1'b0}}, ins[19:15]} : opnd;
                case (f3[1:0])
                    2'b01:   newV = src;
                    2'b10:   newV = oldV | src;
                    default: newV = oldV & ~src;
                endcase
                // Set and clear with a zero source leave the CSR alone
                if (f3[1:0] == 2'b01 || ins[19:15] != 5'd0) begin
                    case (addr)
                        `CSR_MSTATUS:  mStatus  = newV;
                        `CSR_MTVEC:    mTvec    = newV;
                        `CSR_MSCRATCH: mScratch = newV;
                        `CSR_MEPC:     mEpc     = newV;
                        default:       mCause   = newV;
                    endcase
                end
            end
        end
        tabPriv[nTests] = mPriv;
        nTests++;
    endtask

    task automatic addTrap(input logic [`XLEN-1:0] cause, input logic [`XLEN-1:0] npc);
        logic [`XLEN-1:0] base;
        base = {mTvec[`XLEN-1:2], 2'b00};
        tabKind[nTests]  = 1'b1;
        tabCause[nTests] = cause;
        tabArg[nTests]   = npc;
        // Vectored only for interrupts with the MSB shifted out
        tabPc[nTests] = (mTvec[1:0] == 2'b01 && cause[`XLEN-1]) ? base + (cause << 2) : base;
        tabRd[nTests]    = '0;
        tabIll[nTests]   = 1'b0;
        tabRedir[nTests] = 1'b0;
        mCause = cause;
        mEpc   = npc;
        mStatus[`MSTATUS_MPIE]        = mStatus[`MSTATUS_MIE];
        mStatus[`MSTATUS_MIE]         = 1'b0;
        mStatus[`MSTATUS_MPP_LO +: 2] = mPriv;
        mPriv = PRIV_M;
        tabPriv[nTests] = mPriv;
        nTests++;
    endtask

    task automatic buildTable();
        logic [`XLEN-1:0] r1;
        logic [`XLEN-1:0] r2;
        logic [`XLEN-1:0] r3;
        logic [`XLEN-1:0] r4;
        nTests    = 0;
        lfsrState = 32'h90aa;
        mStatus   = '0;
        mTvec     = `MTVEC_RESET;
        mScratch  = 'x;   // No reset on the data CSRs
        mEpc      = 'x;
        mCause    = 'x;
        mPriv     = PRIV_M;
        drawBits(r1);
        drawBits(r2);
        drawBits(r3);
        drawBits(r4);
        // mscratch read-modify-write
        addCsr(csrInstr(F_RW, `CSR_MSCRATCH, 5'd5), r1);
        addCsr(csrInstr(F_RS, `CSR_MSCRATCH, 5'd6), r2);
        addCsr(csrInstr(F_RC, `CSR_MSCRATCH, 5'd0), r3);   // x0 source
        addCsr(csrInstr(F_RS, `CSR_MSCRATCH, 5'd0), r4);
        // MIE by immediate
        addCsr(csrInstr(F_RSI, `CSR_MSTATUS, 5'd8), '0);
        addCsr(csrInstr(F_RCI, `CSR_MSTATUS, 5'd8), '0);
        addTrap(64'd2, 64'h8000_1004);                    // Illegal instruction in direct mode
        addCsr(csrInstr(F_RS, `CSR_MCAUSE, 5'd0), '0);
        addCsr(csrInstr(F_RS, `CSR_MEPC, 5'd0), '0);
        // Vectored mtvec and a timer interrupt
        addCsr(csrInstr(F_RW, `CSR_MTVEC, 5'd7), 64'h2001);
        addCsr(csrInstr(F_RSI, `CSR_MSTATUS, 5'd8), '0);
        addTrap({1'b1, 63'd7}, 64'h8000_2000);
        addCsr(csrInstr(F_RS, `CSR_MSTATUS, 5'd0), '0);
        // Clear MPP, then return to U
        addCsr(csrInstr(F_RC, `CSR_MSTATUS, 5'd8), 64'h1800);
        addCsr(csrInstr(F_RW, `CSR_MEPC, 5'd9), 64'h8000_3000);
        addCsr(INSTR_MRET, '0);
        addCsr(csrInstr(F_RW, `CSR_MSCRATCH, 5'd5), r4);    // Illegal in U
        addCsr(csrInstr(F_RS, `CSR_MSCRATCH, 5'd0), '0);
        addTrap(64'd8, 64'h8000_3008);                    // ECALL from U
        addCsr(csrInstr(F_RS, `CSR_MSTATUS, 5'd0), '0);
        addCsr(csrInstr(F_RS, `CSR_MSCRATCH, 5'd0), '0);
        addCsr(INSTR_MRET, '0);
        addTrap(64'd2, 64'h8000_4000);
        // Illegal in M
        addCsr(csrInstr(F_RS, 12'h344, 5'd0), '0);         // Unimplemented CSR
        addCsr(32'h00100093, '0);                          // addi
    endtask

    //////////////////////////////////////////////////
    // Driver
    //////////////////////////////////////////////////
    task automatic applyEntry(input int i);
        @(negedge CLK);
        curTest  = i;
        curKind  = tabKind[i];
        curRd    = tabRd[i];
        curIll   = tabIll[i];
        curRedir = tabRedir[i];
        curPc    = tabPc[i];
        curPriv  = tabPriv[i];
        if (tabKind[i]) begin
            trapCause = tabCause[i];
            trapNpc   = tabArg[i];
            trapValid = 1'b1;   // One-cycle strobe
            @(negedge CLK);
            trapValid = 1'b0;
            while (doneCount <= i) @(negedge CLK);
        end else begin
            instr    = tabInstr[i];
            rs1Value = tabArg[i];
            req      = 1'b1;
            while (!ack) @(negedge CLK);
            req = 1'b0;
            while (ack) @(negedge CLK);   // Four-phase release
        end
    endtask

    initial begin
        RESET      = 1'b1;
        req        = 1'b0;
        instr      = '0;
        rs1Value   = '0;
        trapValid  = 1'b0;
        trapCause  = '0;
        trapNpc    = '0;
        curTest    = 0;
        curKind    = 1'b0;
        curRd      = '0;
        curIll     = 1'b0;
        curRedir   = 1'b0;
        curPc      = '0;
        curPriv    = PRIV_M;
        tableReady = 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        for (int i = 0; i < nTests; i++) begin
            applyEntry(i);
        end
        while (doneCount < nTests) @(negedge CLK);
        $display("Tests run %0d, errors %0d", doneCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog of 20 cycles per entry plus margin
    initial begin
        wait (tableReady);
        repeat (nTests * 20 + 100) @(posedge CLK);
        $display("Timeout: handshake or trap redirect of test %0d never completed", curTest);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/csrChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csrChecker import csr_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    // Trap strobe as driven to the DUT
    input  logic              trapValid,
    // Observed DUT outputs
    input  logic              ack,
    input  logic [`XLEN-1:0]  rdValue,
    input  logic              illegal,
    input  logic              redirectValid,
    input  logic [`XLEN-1:0]  redirectPc,
    input  logic              trapRedirectValid,
    input  logic [`XLEN-1:0]  trapRedirectPc,
    input  privE              priv,
    // Expected values for the running test
    input  int                testIdx,
    input  logic              expKind,    // 1 for a trap
    input  logic [`XLEN-1:0]  expRd,
    input  logic              expIll,
    input  logic              expRedir,
    input  logic [`XLEN-1:0]  expPc,
    input  logic [1:0]        expPriv,
    output int                doneCount,
    output int                errorCount
);

    logic ackSeen;      // ack at the previous falling edge
    logic strobeSeen;   // trapValid at the last rising edge
    logic bad;          // Current test has a mismatch

    task automatic reportWrong(input string what, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        $display("ERROR %0t: test %0d %s is %h, expected %h", $time, testIdx, what, got, exp);
        bad = 1'b1;
    endtask

    // Common tail of every test
    task automatic closeTest();
        if (priv !== expPriv) reportWrong("priv", priv, expPriv);
        $display("Test %0d %s", testIdx, bad ? "mismatch" : "ok");
        errorCount <= errorCount + (bad ? 1 : 0);
        doneCount  <= doneCount + 1;
    endtask

    //////////////////////////////////////////////////
    // Handshake response
    //////////////////////////////////////////////////
    task automatic checkResponse();
        bad = 1'b0;
        if (expKind) begin
            $display("Test %0d got a CSR response where a trap redirect was due", testIdx);
            bad = 1'b1;
        end
        // Unreset CSRs give an unknown old value
        if (!$isunknown(expRd) && rdValue !== expRd) reportWrong("rdValue", rdValue, expRd);
        if (illegal !== expIll) reportWrong("illegal", illegal, expIll);
        if (redirectValid !== expRedir) reportWrong("redirectValid", redirectValid, expRedir);
        if (expRedir && redirectPc !== expPc) reportWrong("redirectPc", redirectPc, expPc);
        closeTest();
    endtask

    task automatic checkTrap();
        bad = 1'b0;
        if (!expKind) begin
            $display("Test %0d saw a trap redirect pulse without a trap", testIdx);
            bad = 1'b1;
        end
        if (!strobeSeen) begin   // Late or stretched pulse
            $display("Test %0d trap redirect pulse not one cycle after the strobe",
                     testIdx);
            bad = 1'b1;
        end
        if (trapRedirectPc !== expPc) reportWrong("trapRedirectPc", trapRedirectPc, expPc);
        closeTest();
    endtask

    // Strobe as the DUT register file samples it
    always @(posedge CLK) begin
        if (RESET) begin
            strobeSeen <= 1'b0;
        end else begin
            strobeSeen <= trapValid;
        end
    end

    // Registered outputs compared on the falling edge
    always @(negedge CLK) begin
        if (RESET) begin
            ackSeen    <= 1'b0;
            doneCount  <= 0;
            errorCount <= 0;
        end else begin
            ackSeen <= ack;
            if (ack && !ackSeen) begin   // Rising ack
                checkResponse();
            end
            if (trapRedirectValid) begin
                checkTrap();
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csrUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csrUnit import csr_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    // Four-phase request channel
    input  logic              req,
    output logic              ack,
    input  logic [31:0]       instr,
    input  logic [`XLEN-1:0]  rs1Value,
    output logic [`XLEN-1:0]  rdValue,
    output logic              illegal,
    output logic              redirectValid,
    output logic [`XLEN-1:0]  redirectPc,
    // Trap strobe and redirect
    input  logic              trapValid,
    input  logic [`XLEN-1:0]  trapCause,
    input  logic [`XLEN-1:0]  trapNpc,
    output logic              trapRedirectValid,
    output logic [`XLEN-1:0]  trapRedirectPc,
    output privE              priv
);

    csrOpE             op;
    logic [11:0]       csrAddr;
    logic [4:0]        zimm;
    logic              srcZero;
    logic [11:0]       rdAddr;
    logic [`XLEN-1:0]  rdData;
    logic              legal;
    logic              wrEn;
    logic [11:0]       wrAddr;
    logic [`XLEN-1:0]  wrData;
    logic              retEn;
    logic [`XLEN-1:0]  retPc;

    // Instruction fields
    csrDecode csrDecode_inst (
        .instr(instr), .op(op), .csrAddr(csrAddr), .zimm(zimm), .srcZero(srcZero)
    );

    // Handshake and read-modify-write
    csrAccess csrAccess_inst (
        .CLK(CLK), .RESET(RESET), .req(req), .ack(ack),
        .op(op), .csrAddr(csrAddr), .zimm(zimm), .srcZero(srcZero), .rs1Value(rs1Value),
        .rdAddr(rdAddr), .rdData(rdData), .legal(legal),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .retEn(retEn), .retPc(retPc),
        .rdValue(rdValue), .illegal(illegal),
        .redirectValid(redirectValid), .redirectPc(redirectPc)
    );

    // Storage and trap side effects
    csrRegFile csrRegFile_inst (
        .CLK(CLK), .RESET(RESET),
        .rdAddr(rdAddr), .rdData(rdData), .legal(legal),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .retEn(retEn), .retPc(retPc),
        .trapValid(trapValid), .trapCause(trapCause), .trapNpc(trapNpc),
        .trapRedirectValid(trapRedirectValid), .trapRedirectPc(trapRedirectPc),
        .priv(priv)
    );

endmodule

`default_nettype wire

// ==== hdl/csrRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csrRegFile import csr_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    // Read port
    input  logic [11:0]       rdAddr,
    output logic [`XLEN-1:0]  rdData,
    output logic              legal,
    // Write port
    input  logic              wrEn,
    input  logic [11:0]       wrAddr,
    input  logic [`XLEN-1:0]  wrData,
    // MRET
    input  logic              retEn,
    output logic [`XLEN-1:0]  retPc,
    // Trap entry
    input  logic              trapValid,
    input  logic [`XLEN-1:0]  trapCause,
    input  logic [`XLEN-1:0]  trapNpc,
    output logic              trapRedirectValid,
    output logic [`XLEN-1:0]  trapRedirectPc,
    // Current mode
    output privE              priv
);

    logic [`XLEN-1:0]  mstatus;
    logic [`XLEN-1:0]  mtvec;
    logic [`XLEN-1:0]  mscratch;
    logic [`XLEN-1:0]  mepc;
    logic [`XLEN-1:0]  mcause;

    logic [`XLEN-1:0]  readValue;
    logic              implemented;
    logic [`XLEN-1:0]  mstatusWr;   // Legalized mstatus write value
    logic [`XLEN-1:0]  trapBase;
    logic              trapVectored;
    logic [`XLEN-1:0]  trapTarget;

    //////////////////////////////////////////////////
    // Read decode and privilege check
    //////////////////////////////////////////////////
    always_comb begin
        implemented = 1'b1;
        readValue   = '0;
        case (rdAddr)
            `CSR_MSTATUS:  readValue = mstatus;
            `CSR_MTVEC:    readValue = mtvec;
            `CSR_MSCRATCH: readValue = mscratch;
            `CSR_MEPC:     readValue = mepc;
            `CSR_MCAUSE:   readValue = mcause;
            default:       implemented = 1'b0;  // Unknown CSR number
        endcase
    end

    // Address bits 9:8 give the lowest privilege allowed
    assign legal  = implemented && (priv >= rdAddr[9:8]);
    assign rdData = legal ? readValue : '0;
    assign retPc  = mepc;

    // Only MIE, MPIE and MPP are writable
    always_comb begin
        mstatusWr = '0;
        mstatusWr[`MSTATUS_MIE]  = wrData[`MSTATUS_MIE];
        mstatusWr[`MSTATUS_MPIE] = wrData[`MSTATUS_MPIE];
        // MPP holds U or M only
        mstatusWr[`MSTATUS_MPP_LO +: 2] =
            (wrData[`MSTATUS_MPP_LO +: 2] == 2'b11) ? 2'b11 : 2'b00;
    end

    //////////////////////////////////////////////////
    // Trap target
    //////////////////////////////////////////////////
    assign trapBase     = {mtvec[`XLEN-1:2], 2'b00};
    assign trapVectored = (mtvec[1:0] == 2'b01) && trapCause[`XLEN-1];  // Vectored interrupt
    assign trapTarget   = trapVectored ? trapBase + {trapCause[`XLEN-3:0], 2'b00}
                                       : trapBase;

    // Control state: mstatus, mtvec and privilege
    always_ff @(posedge CLK) begin
        if (RESET) begin
            mstatus <= '0;
            mtvec   <= `MTVEC_RESET;
            priv    <= PRIV_M;
        end else if (trapValid) begin
            // Trap entry wins over everything
            mstatus[`MSTATUS_MPIE]        <= mstatus[`MSTATUS_MIE];
            mstatus[`MSTATUS_MIE]         <= 1'b0;
            mstatus[`MSTATUS_MPP_LO +: 2] <= priv;
            priv                          <= PRIV_M;
        end else if (retEn) begin
            mstatus[`MSTATUS_MIE]         <= mstatus[`MSTATUS_MPIE];
            mstatus[`MSTATUS_MPIE]        <= 1'b1;
            mstatus[`MSTATUS_MPP_LO +: 2] <= PRIV_U;
            priv <= privE'(mstatus[`MSTATUS_MPP_LO +: 2]);  // Back to previous mode
        end else if (wrEn) begin
            if (wrAddr == `CSR_MSTATUS) mstatus <= mstatusWr;
            if (wrAddr == `CSR_MTVEC)   mtvec   <= wrData;
        end
    end

    // Data CSRs
    always_ff @(posedge CLK) begin
        if (trapValid) begin
            mcause <= trapCause;
            mepc   <= trapNpc;    // Return address
        end else if (wrEn) begin
            case (wrAddr)
                `CSR_MSCRATCH: mscratch <= wrData;
                `CSR_MEPC:     mepc     <= wrData;
                `CSR_MCAUSE:   mcause   <= wrData;
                default:       ;     // Handled with control state
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Trap redirect pulse
    //////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            trapRedirectValid <= 1'b0;
        end else begin
            trapRedirectValid <= trapValid;  // One cycle after the strobe
        end
    end

    always_ff @(posedge CLK) begin
        if (trapValid) begin
            trapRedirectPc <= trapTarget;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csrAccess.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csrAccess import csr_pkg::*; (
    input  logic              CLK,
    input  logic              RESET,
    // Core handshake
    input  logic              req,
    output logic              ack,
    // Decoded request
    input  csrOpE             op,
    input  logic [11:0]       csrAddr,
    input  logic [4:0]        zimm,
    input  logic              srcZero,
    input  logic [`XLEN-1:0]  rs1Value,
    // Register file side
    output logic [11:0]       rdAddr,
    input  logic [`XLEN-1:0]  rdData,
    input  logic              legal,
    output logic              wrEn,
    output logic [11:0]       wrAddr,
    output logic [`XLEN-1:0]  wrData,
    output logic              retEn,
    input  logic [`XLEN-1:0]  retPc,
    // Response
    output logic [`XLEN-1:0]  rdValue,
    output logic              illegal,
    output logic              redirectValid,
    output logic [`XLEN-1:0]  redirectPc
);

    accStateE          state;
    csrOpE             opReg;       // Latched request
    logic [11:0]       addrReg;
    logic [4:0]        zimmReg;
    logic              srcZeroReg;
    logic [`XLEN-1:0]  rs1Reg;
    logic [`XLEN-1:0]  oldReg;      // Value read in ACC_READ
    logic              legalReg;

    logic              isImm;
    logic              isSetClr;
    logic              isCsrOp;
    logic [`XLEN-1:0]  operand;
    logic [`XLEN-1:0]  newValue;
    logic              respIllegal;

    //////////////////////////////////////////////////
    // Read-modify-write datapath
    //////////////////////////////////////////////////
    assign isImm    = (opReg == CSR_RWI) || (opReg == CSR_RSI) || (opReg == CSR_RCI);
    assign isSetClr = (opReg == CSR_RS) || (opReg == CSR_RC) ||
                      (opReg == CSR_RSI) || (opReg == CSR_RCI);
    assign isCsrOp  = (opReg != CSR_NONE) && (opReg != CSR_MRET);

    assign operand = isImm ? {{(`XLEN-5){1'b0}}, zimmReg} : rs1Reg;  // zimm zero-extended

    always_comb begin
        case (opReg)
            CSR_RS, CSR_RSI: newValue = oldReg | operand;
            CSR_RC, CSR_RCI: newValue = oldReg & ~operand;
            default:         newValue = operand;  // RW forms
        endcase
    end

    assign rdAddr = addrReg;
    assign wrAddr = addrReg;
    assign wrData = newValue;

    // Write only when legal and not a set/clear with a zero source
    assign wrEn  = (state == ACC_WRITE) && isCsrOp && legalReg && !(isSetClr && srcZeroReg);
    assign retEn = (state == ACC_WRITE) && (opReg == CSR_MRET);

    // Non-CSR instructions and failed checks both flag
    assign respIllegal = (opReg == CSR_NONE) || (isCsrOp && !legalReg);

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state         <= ACC_IDLE;
            ack           <= 1'b0;
            illegal       <= 1'b0;
            redirectValid <= 1'b0;
        end else begin
            case (state)
                ACC_IDLE: if (req) state <= ACC_READ;    // Request captured below
                ACC_READ: state <= ACC_WRITE;
                ACC_WRITE: begin
                    state         <= ACC_DONE;
                    ack           <= 1'b1;
                    illegal       <= respIllegal;
                    redirectValid <= (opReg == CSR_MRET);
                end
                ACC_DONE: begin
                    if (!req) begin          // Core released req
                        state <= ACC_IDLE;
                        ack   <= 1'b0;
                    end
                end
                default: state <= ACC_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge CLK) begin
        if (state == ACC_IDLE && req) begin
            opReg      <= op;
            addrReg    <= csrAddr;
            zimmReg    <= zimm;
            srcZeroReg <= srcZero;
            rs1Reg     <= rs1Value;
        end
        if (state == ACC_READ) begin
            oldReg   <= rdData;
            legalReg <= legal;
        end
        if (state == ACC_WRITE) begin
            rdValue    <= (isCsrOp && legalReg) ? oldReg : '0;  // Old value or 0
            redirectPc <= retPc;                                 // mepc for MRET
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csrDecode import csr_pkg::*; (
    input  logic [31:0] instr,
    output csrOpE       op,
    output logic [11:0] csrAddr,
    output logic [4:0]  zimm,
    output logic        srcZero
);

    // SYSTEM major opcode
    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    // Full MRET encoding
    localparam logic [31:0] INSTR_MRET = 32'h30200073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       isSystem;

    //////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////
    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign isSystem = (opcode == OPC_SYSTEM);

    assign csrAddr = instr[31:20];   // CSR number
    assign zimm    = instr[19:15];   // Same bits as rs1

    // rs1 or zimm zero
    // Set and clear must then skip the write
    assign srcZero = (instr[19:15] == 5'd0);

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////
    always_comb begin
        op = CSR_NONE;  // Default for everything unknown
        if (instr == INSTR_MRET) begin
            op = CSR_MRET;
        end else if (isSystem) begin
            case (funct3)
                3'b001:  op = CSR_RW;
                3'b010:  op = CSR_RS;
                3'b011:  op = CSR_RC;
                3'b101:  op = CSR_RWI;
                3'b110:  op = CSR_RSI;
                3'b111:  op = CSR_RCI;
                // ECALL, EBREAK, WFI and reserved
                default: op = CSR_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    // Decoded Zicsr operations plus MRET
    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,  // Not a CSR instruction
        CSR_RW   = 3'd1,
        CSR_RS   = 3'd2,
        CSR_RC   = 3'd3,
        CSR_RWI  = 3'd4,  // Immediate forms use zimm
        CSR_RSI  = 3'd5,
        CSR_RCI  = 3'd6,
        CSR_MRET = 3'd7
    } csrOpE;

    // Privilege levels, only U and M here
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } privE;

    // Access sequencer states
    typedef enum logic [1:0] {
        ACC_IDLE  = 2'd0,  // Waiting for req
        ACC_READ  = 2'd1,  // CSR read in flight
        ACC_WRITE = 2'd2,  // Write or return applied
        ACC_DONE  = 2'd3   // ack high until req drops
    } accStateE;

endpackage

`default_nettype wire

// ==== include/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Data path width
`define XLEN 64

//////////////////////////////////////////////////
// Implemented machine CSR numbers
//////////////////////////////////////////////////
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

//////////////////////////////////////////////////
// mstatus field positions
//////////////////////////////////////////////////
`define MSTATUS_MIE    3   // Global M interrupt enable
`define MSTATUS_MPIE   7   // Enable before the last trap
`define MSTATUS_MPP_LO 11  // Two bits, privilege before the last trap

// Trap vector after reset
`define MTVEC_RESET 64'h100

`endif
